// ==== prog_rom.hex ====
// program rom image, one 32-bit word per line in hex
// line n holds rom word n, byte address n*4
00000093
00100113
002081b3
00302023
00002203
00420233
fe021ee3
80000337
00632023
00032383
007383b3
00732223
00432403
00840433
0000006f
deadc0de

// ==== dual_slot_sram.f ====
soc_bus_pkg.sv
sram_pkg.sv
cpu_bus_if.sv
prog_rom.sv
slot_sequencer.sv
sram_datapath.sv
two_port.sv
soc_mem_top.sv
sram_model.sv
soc_mem_assert.sv
tb_soc_mem.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_soc_mem -f dual_slot_sram.f \
    -o sim_soc_mem > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_soc_mem > sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== tb_soc_mem.sv ====
`default_nettype none

module tb_soc_mem;
    import soc_bus_pkg::*;

    localparam int ROM_WORDS     = 16;
    localparam int TOTAL_CYCLES  = 5 + 20 + 6 + 10 + 6 + 302;
    localparam int WATCHDOG_TIME = TOTAL_CYCLES * 4 + 400;
    localparam addr_t SR         = 32'h8000_0000;

    logic clk, clk2x, arst_n;
    addr_t ibus_address, dbus_address;
    be_t ibus_byteenable, dbus_byteenable;
    logic ibus_read, ibus_write, dbus_read, dbus_write;
    data_t ibus_wrdata, dbus_wrdata, ibus_rddata, dbus_rddata;
    ram_addr_t ram_address;
    wire [31:0] ram_data;
    logic ram_wr_n, ram_rd_n;
    be_t ram_dataenable;

    data_t rom_ref [ROM_WORDS];
    data_t ref_mem [logic [7:0]];
    logic ib_pend_v, db_pend_v, ib_cur_v, db_cur_v;
    data_t ib_pend, db_pend, ib_cur, db_cur;
    int errors, checks, tests, err_start;

    soc_mem_top #(.ROM_WORDS(ROM_WORDS)) soc_mem_top_inst (.*);
    sram_model sram_model_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // starts high so its rising edges line up with clk
    initial begin
        clk2x = 1'b1;
        forever #1 clk2x = ~clk2x;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("sim failed");
        $finish;
    end

    function automatic data_t ref_read(addr_t a);
        logic [7:0] k;
        k = a[9:2];
        if (ref_mem.exists(k)) begin
            return ref_mem[k];
        end
        return {8'h5a, k, ~k, k};
    endfunction

    task automatic ref_write(addr_t a, be_t be, data_t wd);
        data_t w;
        w = ref_read(a);
        for (int l = 0; l < 4; l++) begin
            if (be[l]) begin
                w[8*l +: 8] = wd[8*l +: 8];
            end
        end
        ref_mem[a[9:2]] = w;
    endtask

    task automatic check_outputs();
        if (ib_cur_v) begin
            checks++;
            assert (ibus_rddata === ib_cur) else begin
                errors++;
                $display("Fail ibus_rddata expected %08h got %08h", ib_cur, ibus_rddata);
            end
        end
        if (db_cur_v) begin
            checks++;
            assert (dbus_rddata === db_cur) else begin
                errors++;
                $display("Fail dbus_rddata expected %08h got %08h", db_cur, dbus_rddata);
            end
        end
    endtask

    // one clk cycle of requests; reference follows ibus slot then dbus slot
    task automatic do_cycle(
        input logic ir, input logic iw, input addr_t ia, input be_t ibe, input data_t iwd,
        input logic dr, input logic dw, input addr_t da, input be_t dbe, input data_t dwd
    );
        @(posedge clk);
        ibus_read <= ir;
        ibus_write <= iw;
        ibus_address <= ia;
        ibus_byteenable <= ibe;
        ibus_wrdata <= iwd;
        dbus_read <= dr;
        dbus_write <= dw;
        dbus_address <= da;
        dbus_byteenable <= dbe;
        dbus_wrdata <= dwd;
        ib_pend_v = ir;
        if (ir) begin
            ib_pend = ia[ROM_SEL_BIT] ? ref_read(ia) : rom_ref[ia[5:2]];
        end
        if (iw && ia[ROM_SEL_BIT]) begin
            ref_write(ia, ibe, iwd);
        end
        db_pend_v = dr;
        if (dr) begin
            db_pend = ref_read(da);
        end
        if (dw) begin
            ref_write(da, dbe, dwd);
        end
        @(negedge clk);
        check_outputs();
        ib_cur_v = ib_pend_v;
        ib_cur = ib_pend;
        db_cur_v = db_pend_v;
        db_cur = db_pend;
    endtask

    task automatic idle_cycle();
        do_cycle('0, '0, '0, '0, '0, '0, '0, '0, '0, '0);
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %s done, %0d errors", name, errors - err_start);
        err_start = errors;
    endtask

    initial begin
        logic [1:0] iop, dop;
        addr_t ia, da;
        void'($urandom(32'h1586));
        $readmemh("prog_rom.hex", rom_ref);
        {errors, checks, tests, err_start} = '0;
        {ib_pend_v, db_pend_v, ib_cur_v, db_cur_v} = '0;
        {ib_pend, db_pend, ib_cur, db_cur} = '0;
        arst_n = 1'b0;
        // requests held active during reset, the sram must stay idle
        {ibus_read, ibus_write, dbus_read, dbus_write} = 4'b1001;
        ibus_address = SR + 28;
        dbus_address = SR + 28;
        ibus_wrdata = '0;
        dbus_wrdata = 32'hffff_ffff;
        {ibus_byteenable, dbus_byteenable} = '1;
        repeat (4) @(posedge clk);
        {ibus_read, ibus_write, dbus_read, dbus_write} <= '0;
        {ibus_address, dbus_address, ibus_wrdata, dbus_wrdata} <= '0;
        {ibus_byteenable, dbus_byteenable} <= '0;
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        checks++;
        assert (ibus_rddata === '0) else begin
            errors++;
            $display("Fail ibus_rddata expected 00000000 got %08h", ibus_rddata);
        end
        checks++;
        assert (dbus_rddata === '0) else begin
            errors++;
            $display("Fail dbus_rddata expected 00000000 got %08h", dbus_rddata);
        end
        for (int i = 0; i < ROM_WORDS; i++) begin
            do_cycle(1'b1, '0, addr_t'(i * 4), 4'hf, '0, '0, '0, '0, '0, '0);
        end
        idle_cycle();
        end_test("reset_rom");

        do_cycle('0, '0, '0, '0, '0, '0, 1'b1, SR + 8, 4'hf, 32'hdeadbeef);
        idle_cycle();
        do_cycle('0, '0, '0, '0, '0, 1'b1, '0, SR + 8, 4'hf, '0);
        idle_cycle();
        end_test("word_write_read");

        do_cycle('0, '0, '0, '0, '0, '0, 1'b1, SR + 12, 4'hf, 32'h11223344);
        do_cycle('0, '0, '0, '0, '0, '0, 1'b1, SR + 12, 4'b0010, 32'haabbccdd);
        do_cycle('0, '0, '0, '0, '0, '0, 1'b1, SR + 12, 4'b1100, 32'h55667788);
        do_cycle('0, '0, '0, '0, '0, 1'b1, '0, SR + 12, 4'hf, '0);
        do_cycle('0, 1'b1, SR + 16, 4'hf, 32'h01020304, '0, '0, '0, '0, '0);
        do_cycle('0, 1'b1, SR + 16, 4'b0001, 32'hf0e0d0c0, '0, '0, '0, '0, '0);
        do_cycle('0, 1'b1, SR + 16, 4'b0110, 32'h99887766, '0, '0, '0, '0, '0);
        do_cycle(1'b1, '0, SR + 16, 4'hf, '0, '0, '0, '0, '0, '0);
        idle_cycle();
        end_test("byte_enables");

        do_cycle('0, '0, '0, '0, '0, '0, 1'b1, SR + 20, 4'hf, 32'h0badf00d);
        do_cycle(1'b1, '0, SR + 20, 4'hf, '0, '0, 1'b1, SR + 20, 4'hf, 32'hcafe1234);
        do_cycle(1'b1, '0, SR + 20, 4'hf, '0, '0, '0, '0, '0, '0);
        do_cycle('0, 1'b1, SR + 24, 4'hf, 32'h1111aaaa, '0, 1'b1, SR + 24, 4'hf, 32'h2222bbbb);
        do_cycle('0, '0, '0, '0, '0, 1'b1, '0, SR + 24, 4'hf, '0);
        idle_cycle();
        end_test("slot_order");

        for (int n = 0; n < 300; n++) begin
            iop = 2'($urandom_range(0, 2));
            dop = 2'($urandom_range(0, 2));
            ia = SR + addr_t'($urandom_range(0, 7) * 4);
            if (iop == 2'd1 && $urandom_range(0, 1) == 0) begin
                ia = addr_t'($urandom_range(0, ROM_WORDS - 1) * 4);
            end
            da = SR + addr_t'($urandom_range(0, 7) * 4);
            do_cycle(iop == 2'd1, iop == 2'd2, ia, be_t'($urandom_range(1, 15)), $urandom(),
                     dop == 2'd1, dop == 2'd2, da, be_t'($urandom_range(1, 15)), $urandom());
        end
        idle_cycle();
        end_test("random_traffic");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_mem_assert.sv ====
`default_nettype none

module soc_mem_assert (
    input logic             clk2x,
    input logic             arst_n,
    input logic             ram_rd_n,
    input logic             ram_wr_n,
    input soc_bus_pkg::be_t ram_dataenable
);

    // one direction per slot
    property no_rd_wr_overlap;
        @(posedge clk2x) !(!ram_rd_n && !ram_wr_n);
    endproperty

    property idle_in_reset;
        @(posedge clk2x) !arst_n |-> (ram_rd_n && ram_wr_n);
    endproperty

    // an access always enables at least one lane
    property lanes_on_access;
        @(posedge clk2x) disable iff (!arst_n)
            (!ram_rd_n || !ram_wr_n) |-> (ram_dataenable != 4'b0000);
    endproperty

    rd_wr_overlap_a: assert property (no_rd_wr_overlap)
        else $error("ram_rd_n and ram_wr_n low together");
    reset_idle_a: assert property (idle_in_reset)
        else $error("sram strobe active during reset");
    lanes_a: assert property (lanes_on_access)
        else $error("sram access with no byte lane enabled");

endmodule

bind soc_mem_top soc_mem_assert soc_mem_assert_inst (
    .clk2x          (clk2x),
    .arst_n         (arst_n),
    .ram_rd_n       (ram_rd_n),
    .ram_wr_n       (ram_wr_n),
    .ram_dataenable (ram_dataenable)
);

`default_nettype wire

// ==== sram_model.sv ====
`default_nettype none

module sram_model (
    input  logic                   clk2x,
    input  soc_bus_pkg::ram_addr_t ram_address,
    inout  wire soc_bus_pkg::data_t ram_data,
    input  logic                   ram_wr_n,
    input  logic                   ram_rd_n,
    input  soc_bus_pkg::be_t       ram_dataenable
);
    import soc_bus_pkg::*;

    data_t mem [256];
    data_t rd_word;

    // power-up pattern built from every index bit
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'h5a, 8'(i), ~8'(i), 8'(i)};
        end
    end

    always_comb begin
        rd_word = mem[ram_address[7:0]];
    end

    assign ram_data = ram_rd_n ? {32{1'bz}} : rd_word;

    // write lands in the middle of the strobe, once pins have settled
    always @(negedge clk2x) begin
        if (!ram_wr_n) begin
            for (int l = 0; l < 4; l++) begin
                if (ram_dataenable[l]) begin
                    mem[ram_address[7:0]][8*l +: 8] = ram_data[8*l +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== soc_mem_top.sv ====
`default_nettype none

module soc_mem_top #(
    parameter int ROM_WORDS = soc_bus_pkg::ROM_WORDS_DEFAULT
) (
    input  logic                   clk,
    input  logic                   clk2x,
    input  logic                   arst_n,
    input  soc_bus_pkg::addr_t     ibus_address,
    input  soc_bus_pkg::be_t       ibus_byteenable,
    input  logic                   ibus_read,
    input  logic                   ibus_write,
    input  soc_bus_pkg::data_t     ibus_wrdata,
    output soc_bus_pkg::data_t     ibus_rddata,
    input  soc_bus_pkg::addr_t     dbus_address,
    input  soc_bus_pkg::be_t       dbus_byteenable,
    input  logic                   dbus_read,
    input  logic                   dbus_write,
    input  soc_bus_pkg::data_t     dbus_wrdata,
    output soc_bus_pkg::data_t     dbus_rddata,
    output soc_bus_pkg::ram_addr_t ram_address,
    inout  wire soc_bus_pkg::data_t ram_data,
    output logic                   ram_wr_n,
    output logic                   ram_rd_n,
    output soc_bus_pkg::be_t       ram_dataenable
);
    import soc_bus_pkg::*;

    data_t rom_data;

    cpu_bus_if ibus_if ();
    cpu_bus_if dbus_if ();

    assign ibus_if.address    = ibus_address;
    assign ibus_if.byteenable = ibus_byteenable;
    assign ibus_if.read       = ibus_read;
    assign ibus_if.write      = ibus_write;
    assign ibus_if.wrdata     = ibus_wrdata;

    assign dbus_if.address    = dbus_address;
    assign dbus_if.byteenable = dbus_byteenable;
    assign dbus_if.read       = dbus_read;
    assign dbus_if.write      = dbus_write;
    assign dbus_if.wrdata     = dbus_wrdata;

    // rom sits on the ibus only
    prog_rom #(
        .ROM_WORDS (ROM_WORDS)
    ) prog_rom_inst (
        .clk     (clk),
        .address (ibus_address),
        .data    (rom_data)
    );

    two_port two_port_inst (
        .clk            (clk),
        .clk2x          (clk2x),
        .arst_n         (arst_n),
        .ibus           (ibus_if.controller),
        .dbus           (dbus_if.controller),
        .rom_data       (rom_data),
        .ibus_rddata    (ibus_rddata),
        .dbus_rddata    (dbus_rddata),
        .ram_address    (ram_address),
        .ram_data       (ram_data),
        .ram_wr_n       (ram_wr_n),
        .ram_rd_n       (ram_rd_n),
        .ram_dataenable (ram_dataenable)
    );

endmodule

`default_nettype wire

// ==== two_port.sv ====
`default_nettype none

module two_port (
    input  logic                   clk,
    input  logic                   clk2x,
    input  logic                   arst_n,
    cpu_bus_if.controller          ibus,
    cpu_bus_if.controller          dbus,
    input  soc_bus_pkg::data_t     rom_data,
    output soc_bus_pkg::data_t     ibus_rddata,
    output soc_bus_pkg::data_t     dbus_rddata,
    output soc_bus_pkg::ram_addr_t ram_address,
    inout  wire soc_bus_pkg::data_t ram_data,
    output logic                   ram_wr_n,
    output logic                   ram_rd_n,
    output soc_bus_pkg::be_t       ram_dataenable
);
    import sram_pkg::*;

    slot_e slot;

    slot_sequencer slot_sequencer_inst (
        .clk2x  (clk2x),
        .arst_n (arst_n),
        .slot   (slot)
    );

    // sram pins follow whichever bus owns the slot
    sram_datapath sram_datapath_inst (
        .clk            (clk),
        .clk2x          (clk2x),
        .arst_n         (arst_n),
        .slot           (slot),
        .ibus           (ibus),
        .dbus           (dbus),
        .rom_data       (rom_data),
        .ibus_rddata    (ibus_rddata),
        .dbus_rddata    (dbus_rddata),
        .ram_address    (ram_address),
        .ram_data       (ram_data),
        .ram_wr_n       (ram_wr_n),
        .ram_rd_n       (ram_rd_n),
        .ram_dataenable (ram_dataenable)
    );

endmodule

`default_nettype wire

// ==== sram_datapath.sv ====
`default_nettype none

module sram_datapath (
    input  logic                   clk,
    input  logic                   clk2x,
    input  logic                   arst_n,
    input  sram_pkg::slot_e        slot,
    cpu_bus_if.controller          ibus,
    cpu_bus_if.controller          dbus,
    input  soc_bus_pkg::data_t     rom_data,
    output soc_bus_pkg::data_t     ibus_rddata,
    output soc_bus_pkg::data_t     dbus_rddata,
    output soc_bus_pkg::ram_addr_t ram_address,
    inout  wire soc_bus_pkg::data_t ram_data,
    output logic                   ram_wr_n,
    output logic                   ram_rd_n,
    output soc_bus_pkg::be_t       ram_dataenable
);
    import soc_bus_pkg::*;
    import sram_pkg::*;

    logic  ibus_sram;
    logic  act_rd;
    logic  act_wr;
    addr_t act_addr;
    be_t   act_be;
    data_t act_wdata;
    data_t ibus_cap;
    data_t ibus_ram_q;
    logic  ibus_rom_q;

    assign ibus_sram = ibus.address[ROM_SEL_BIT];

    // request of the bus that owns the current slot
    always_comb begin
        act_rd    = 1'b0;
        act_wr    = 1'b0;
        act_addr  = ibus.address;
        act_be    = ibus.byteenable;
        act_wdata = ibus.wrdata;
        case (slot)
            SLOT_IBUS: begin
                act_rd = ibus.read & ibus_sram;
                act_wr = ibus.write & ibus_sram;
            end
            SLOT_DBUS: begin
                act_addr  = dbus.address;
                act_be    = dbus.byteenable;
                act_wdata = dbus.wrdata;
                act_rd    = dbus.read;
                act_wr    = dbus.write;
            end
            default: begin
            end
        endcase
    end

    assign ram_address    = act_addr[RAM_ADDR_W+1:2];
    assign ram_rd_n       = ~act_rd;
    assign ram_wr_n       = ~act_wr;
    assign ram_dataenable = (act_rd | act_wr) ? act_be : {RAM_BE_W{1'b0}};
    assign ram_data       = act_wr ? act_wdata : {RAM_DATA_W{1'bz}};

    // ibus slot ends mid-cycle on a clk2x edge
    always_ff @(posedge clk2x) begin
        if (slot == SLOT_IBUS) begin
            ibus_cap <= ram_data;
        end
    end

    // the dbus slot ends on the clk edge itself, so its data goes straight
    // into the output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ibus_rom_q  <= 1'b0;
            ibus_ram_q  <= '0;
            dbus_rddata <= '0;
        end else begin
            ibus_rom_q <= ibus.read & ~ibus_sram;
            if (ibus.read && ibus_sram) begin
                ibus_ram_q <= ibus_cap;
            end
            if (dbus.read && slot == SLOT_DBUS) begin
                dbus_rddata <= ram_data;
            end
        end
    end

    // rom data is already registered inside the rom
    assign ibus_rddata = ibus_rom_q ? rom_data : ibus_ram_q;

endmodule

`default_nettype wire

// ==== slot_sequencer.sv ====
`default_nettype none

module slot_sequencer (
    input  logic            clk2x,
    input  logic            arst_n,
    output sram_pkg::slot_e slot
);
    import sram_pkg::*;

    slot_e slot_nxt;

    // reset is released on a clk edge, so the first clk2x edge seen out of
    // reset falls in the middle of a clk cycle and opens a dbus slot
    always_comb begin
        case (slot)
            SLOT_IBUS: begin
                slot_nxt = SLOT_DBUS;
            end
            SLOT_DBUS: begin
                slot_nxt = SLOT_IBUS;
            end
            default: begin
                slot_nxt = SLOT_DBUS;
            end
        endcase
    end

    // ibus then dbus inside every clk cycle from here on
    always_ff @(posedge clk2x or negedge arst_n) begin
        if (!arst_n) begin
            slot <= SLOT_IDLE;
        end else begin
            slot <= slot_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== prog_rom.sv ====
`default_nettype none

module prog_rom #(
    parameter int ROM_WORDS = soc_bus_pkg::ROM_WORDS_DEFAULT
) (
    input  logic               clk,
    input  soc_bus_pkg::addr_t address,
    output soc_bus_pkg::data_t data
);
    import soc_bus_pkg::*;

    localparam int IDX_W = $clog2(ROM_WORDS);

    data_t            mem [ROM_WORDS];
    logic [IDX_W-1:0] word_idx;

    initial begin
        $readmemh("prog_rom.hex", mem);
    end

    // word index wraps at the rom depth
    assign word_idx = address[IDX_W+1:2];

    always_ff @(posedge clk) begin
        data <= mem[word_idx];
    end

endmodule

`default_nettype wire

// ==== cpu_bus_if.sv ====
`default_nettype none

interface cpu_bus_if;
    import soc_bus_pkg::*;

    addr_t address;
    be_t   byteenable;
    logic  read;
    logic  write;
    data_t wrdata;

    // memory side, only samples the request
    modport controller (
        input address,
        input byteenable,
        input read,
        input write,
        input wrdata
    );

    // cpu side, issues single-cycle strobes
    modport source (
        output address,
        output byteenable,
        output read,
        output write,
        output wrdata
    );

endinterface

`default_nettype wire

// ==== sram_pkg.sv ====
`default_nettype none

package sram_pkg;

    // pin widths of the external asynchronous sram
    localparam int RAM_ADDR_W = 30;
    localparam int RAM_DATA_W = 32;
    localparam int RAM_BE_W   = 4;

    // owner of the sram pins during the current clk2x cycle
    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_IBUS,
        SLOT_DBUS
    } slot_e;

endpackage

`default_nettype wire

// ==== soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // byte address and data word as seen by both cpu buses
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // one enable per byte lane, bit 0 is the low byte
    typedef logic [3:0] be_t;

    // word address on the sram pins, byte address bits 31:2
    typedef logic [29:0] ram_addr_t;

    // ibus address bit that selects sram (set) or rom (clear)
    localparam int ROM_SEL_BIT = 31;

    // program rom depth in 32-bit words
    localparam int ROM_WORDS_DEFAULT = 16;

endpackage

`default_nettype wire
